// File: Bender.yml
package:
  name: breq_fifos

sources:
  # RTL, package first
  - files:
      - hw/breq_pkg.sv
      - hw/breq_capture.sv
      - hw/breq_fifo.sv
      - hw/broad_arbiter.sv
      - hw/breq_fifos.sv

  # Testbench, tasks come in through the include path
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_breq_fifos.sv

// File: breq_fifos.f
+incdir+tb
hw/breq_pkg.sv
hw/breq_capture.sv
hw/breq_fifo.sv
hw/broad_arbiter.sv
hw/breq_fifos.sv
tb/tb_breq_fifos.sv

// File: hw/breq_capture.sv
`timescale 1ns/1ps
`default_nettype none

module breq_capture
  import breq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [MBUS_CMD_W-1:0] mbus_cmd_i   [NUM_CPU],
  input  logic [ADDR_W-1:0]     mbus_addr_i  [NUM_CPU],
  input  logic                  fifo_full_i  [NUM_CPU],
  output logic                  mbus_ack_o   [NUM_CPU],
  output logic                  fifo_wr_o    [NUM_CPU],
  output breq_entry_t           fifo_entry_o [NUM_CPU]
);

  // Registered acks, one per CPU
  logic [NUM_CPU-1:0] ack_q;
  // Acks to be raised at the coming edge
  logic [NUM_CPU-1:0] ack_set;
  // Command decoded into request type
  logic [BREQ_TYPE_W-1:0] req_type [NUM_CPU];
  // Rolling ID base shared by all CPUs
  logic [BREQ_ID_BASE_W-1:0] id_base_q;
  // Entry captured with the ack, written to the FIFO during the ack cycle
  breq_entry_t entry_q [NUM_CPU];

  // ==============================
  // Command decode
  // ==============================
  always_comb
  begin
    for (int c = 0; c < NUM_CPU; c++)
    begin
      case (mbus_cmd_i[c])
        MBUS_CMD_WR_BROAD: req_type[c] = BREQ_TYPE_WR;
        MBUS_CMD_RD_BROAD: req_type[c] = BREQ_TYPE_RD;
        // Plain reads, writes and NOP are not broadcast
        default:           req_type[c] = BREQ_TYPE_NOP;
      endcase
      // Only broadcasts, only with FIFO room, never two cycles in a row
      ack_set[c] = ~ack_q[c] & (req_type[c] != BREQ_TYPE_NOP) & ~fifo_full_i[c];
    end
  end

  // ==============================
  // Acks and ID base
  // ==============================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ack_q     <= '0;
      id_base_q <= '0;
    end
    else
    begin
      ack_q <= ack_set;
      // Base advances once per edge with any new request
      // Each CPU owns one low-bit slot so IDs stay unique
      if (|ack_set)
      begin
        id_base_q <= id_base_q + 1'b1;
      end
    end
  end

  // Entry payload, captured together with the ack
  always_ff @(posedge clk)
  begin
    for (int c = 0; c < NUM_CPU; c++)
    begin
      if (ack_set[c])
      begin
        entry_q[c].addr     <= mbus_addr_i[c];
        entry_q[c].req_type <= req_type[c];
        // CPU 0 takes slot 3, CPU 3 takes slot 0
        entry_q[c].id       <= {id_base_q, CPU_ID_W'(NUM_CPU - 1 - c)};
      end
    end
  end

  // ==============================
  // Outputs
  // ==============================
  for (genvar g = 0; g < NUM_CPU; g++)
  begin : g_out
    assign mbus_ack_o[g]   = ack_q[g];
    // FIFO write coincides with the ack
    assign fifo_wr_o[g]    = ack_q[g];
    assign fifo_entry_o[g] = entry_q[g];
  end

endmodule

`default_nettype wire

// File: hw/breq_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module breq_fifo
  import breq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        wr_i,
  input  logic        rd_i,
  input  breq_entry_t data_i,
  output breq_entry_t data_o,
  output logic        empty_o,
  output logic        full_o
);

  // Storage, no reset
  breq_entry_t mem [BREQ_FIFO_DEPTH];

  logic [BREQ_PTR_W-1:0] wr_ptr;
  logic [BREQ_PTR_W-1:0] rd_ptr;
  logic [BREQ_PTR_W-1:0] rd_ptr_nxt;
  // Used entries, wraps to 0 both when empty and when full
  logic [BREQ_PTR_W-1:0] fill;
  logic                  empty_q;
  logic                  full_q;
  // Net change of occupancy this cycle
  logic                  grow;
  logic                  shrink;
  // Next entry is the one being written right now
  logic                  bypass;

  assign rd_ptr_nxt = rd_ptr + 1'b1;
  assign fill       = wr_ptr - rd_ptr;
  assign grow       = wr_i & ~rd_i;
  assign shrink     = rd_i & ~wr_i;
  assign bypass     = wr_i & (wr_ptr == rd_ptr_nxt);

  // ==============================
  // Write side
  // ==============================
  always_ff @(posedge clk)
  begin
    if (wr_i)
    begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_i)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_i)
      begin
        rd_ptr <= rd_ptr_nxt;
      end
    end
  end

  // ==============================
  // Show-ahead output register
  // ==============================
  always_ff @(posedge clk)
  begin
    // Empty, so catch the incoming entry for next cycle
    if (empty_q)
    begin
      data_o <= data_i;
    end
    // Advance to the following entry
    else if (rd_i)
    begin
      data_o <= bypass ? data_i : mem[rd_ptr_nxt];
    end
    else
    begin
      data_o <= mem[rd_ptr];
    end
  end

  // ==============================
  // Flags
  // ==============================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end
    else
    begin
      // Last entry leaves
      if (shrink && fill == BREQ_PTR_W'(1))
      begin
        empty_q <= 1'b1;
      end
      else if (grow)
      begin
        empty_q <= 1'b0;
      end
      // Last free slot taken
      if (grow && fill == BREQ_PTR_W'(BREQ_FIFO_DEPTH - 1))
      begin
        full_q <= 1'b1;
      end
      else if (shrink)
      begin
        full_q <= 1'b0;
      end
    end
  end

  assign empty_o = empty_q;
  assign full_o  = full_q;

endmodule

`default_nettype wire

// File: hw/breq_fifos.sv
`timescale 1ns/1ps
`default_nettype none

module breq_fifos
  import breq_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // Main buses
  input  logic [MBUS_CMD_W-1:0]  mbus_cmd_i  [NUM_CPU],
  input  logic [ADDR_W-1:0]      mbus_addr_i [NUM_CPU],
  output logic                   mbus_ack_o  [NUM_CPU],
  // Broadcast FIFO side
  input  logic                   broad_full_i,
  output logic                   broad_wr_o,
  output logic [ADDR_W-1:0]      broad_addr_o,
  output logic [BREQ_TYPE_W-1:0] broad_type_o,
  output logic [CPU_ID_W-1:0]    broad_cpu_id_o,
  output logic [BREQ_ID_W-1:0]   broad_id_o
);

  logic        fifo_wr    [NUM_CPU];
  logic        fifo_rd    [NUM_CPU];
  logic        fifo_full  [NUM_CPU];
  logic        fifo_empty [NUM_CPU];
  breq_entry_t fifo_entry [NUM_CPU];
  breq_entry_t fifo_head  [NUM_CPU];

  // ==============================
  // Capture of bus commands
  // ==============================
  breq_capture u_capture (
    .clk          (clk),
    .rst          (rst),
    .mbus_cmd_i   (mbus_cmd_i),
    .mbus_addr_i  (mbus_addr_i),
    .fifo_full_i  (fifo_full),
    .mbus_ack_o   (mbus_ack_o),
    .fifo_wr_o    (fifo_wr),
    .fifo_entry_o (fifo_entry)
  );

  // ==============================
  // Per-CPU request FIFOs
  // ==============================
  for (genvar g = 0; g < NUM_CPU; g++)
  begin : g_fifo
    breq_fifo u_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_i    (fifo_wr[g]),
      .rd_i    (fifo_rd[g]),
      .data_i  (fifo_entry[g]),
      .data_o  (fifo_head[g]),
      .empty_o (fifo_empty[g]),
      .full_o  (fifo_full[g])
    );
  end

  // Round robin toward the broadcast FIFO
  broad_arbiter u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .fifo_empty_i   (fifo_empty),
    .fifo_head_i    (fifo_head),
    .broad_full_i   (broad_full_i),
    .fifo_rd_o      (fifo_rd),
    .broad_wr_o     (broad_wr_o),
    .broad_addr_o   (broad_addr_o),
    .broad_type_o   (broad_type_o),
    .broad_cpu_id_o (broad_cpu_id_o),
    .broad_id_o     (broad_id_o)
  );

endmodule

`default_nettype wire

// File: hw/breq_pkg.sv
`default_nettype none

package breq_pkg;

  // ==============================
  // Sizes
  // ==============================
  localparam int NUM_CPU        = 4;
  localparam int CPU_ID_W       = 2;
  localparam int ADDR_W         = 32;
  // Two entries per CPU, power of two so the pointers wrap on their own
  localparam int BREQ_FIFO_DEPTH = 2;
  localparam int BREQ_PTR_W     = $clog2(BREQ_FIFO_DEPTH);

  // ==============================
  // Main bus commands
  // ==============================
  localparam int MBUS_CMD_W = 3;
  localparam logic [MBUS_CMD_W-1:0] MBUS_CMD_NOP      = 3'd0;
  localparam logic [MBUS_CMD_W-1:0] MBUS_CMD_WR       = 3'd1;
  localparam logic [MBUS_CMD_W-1:0] MBUS_CMD_RD       = 3'd2;
  localparam logic [MBUS_CMD_W-1:0] MBUS_CMD_WR_BROAD = 3'd3;
  localparam logic [MBUS_CMD_W-1:0] MBUS_CMD_RD_BROAD = 3'd4;

  // ==============================
  // Broadcast request types
  // ==============================
  localparam int BREQ_TYPE_W = 2;
  localparam logic [BREQ_TYPE_W-1:0] BREQ_TYPE_NOP = 2'd0;
  localparam logic [BREQ_TYPE_W-1:0] BREQ_TYPE_WR  = 2'd1;
  localparam logic [BREQ_TYPE_W-1:0] BREQ_TYPE_RD  = 2'd2;

  // Request ID is a rolling base plus one slot per CPU
  localparam int BREQ_ID_W      = 7;
  localparam int BREQ_ID_BASE_W = BREQ_ID_W - CPU_ID_W;

  // One stored request, 41 bits
  typedef struct packed {
    logic [ADDR_W-1:0]      addr;
    logic [BREQ_TYPE_W-1:0] req_type;
    logic [BREQ_ID_W-1:0]   id;
  } breq_entry_t;

endpackage

`default_nettype wire

// File: hw/broad_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module broad_arbiter
  import breq_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fifo_empty_i [NUM_CPU],
  input  breq_entry_t            fifo_head_i  [NUM_CPU],
  input  logic                   broad_full_i,
  output logic                   fifo_rd_o    [NUM_CPU],
  output logic                   broad_wr_o,
  output logic [ADDR_W-1:0]      broad_addr_o,
  output logic [BREQ_TYPE_W-1:0] broad_type_o,
  output logic [CPU_ID_W-1:0]    broad_cpu_id_o,
  output logic [BREQ_ID_W-1:0]   broad_id_o
);

  // One-hot round-robin pointer
  logic [NUM_CPU-1:0]  prio_q;
  // FIFOs holding a request
  logic [NUM_CPU-1:0]  req;
  // One-hot winner, may be zero
  logic [NUM_CPU-1:0]  sel_oh;
  logic [CPU_ID_W-1:0] sel_idx;
  // Winner gated by broadcast FIFO room
  logic [NUM_CPU-1:0]  grant;

  // Cyclic left rotate of a one-hot vector
  function automatic logic [NUM_CPU-1:0] rotl(
    input logic [NUM_CPU-1:0] v,
    input int unsigned        n
  );
    rotl = (v << n) | (v >> (NUM_CPU - n));
  endfunction

  // ==============================
  // Selection
  // ==============================
  always_comb
  begin
    sel_oh  = '0;
    sel_idx = '0;
    for (int c = 0; c < NUM_CPU; c++)
    begin
      req[c] = ~fifo_empty_i[c];
    end
    // Walk from the farthest candidate back to the priority holder
    // so the nearest non-empty FIFO is the one left standing
    for (int k = NUM_CPU - 1; k >= 0; k--)
    begin
      if (|(rotl(prio_q, k) & req))
      begin
        sel_oh = rotl(prio_q, k);
      end
    end
    // One-hot to index, the index is also the CPU ID
    for (int c = 0; c < NUM_CPU; c++)
    begin
      if (sel_oh[c])
      begin
        sel_idx = CPU_ID_W'(c);
      end
    end
  end

  assign grant = sel_oh & {NUM_CPU{~broad_full_i}};

  // ==============================
  // Toward the FIFOs and the broadcast FIFO
  // ==============================
  for (genvar g = 0; g < NUM_CPU; g++)
  begin : g_rd
    assign fifo_rd_o[g] = grant[g];
  end

  // Write and read happen in the same cycle
  assign broad_wr_o     = |grant;
  assign broad_addr_o   = fifo_head_i[sel_idx].addr;
  assign broad_type_o   = fifo_head_i[sel_idx].req_type;
  assign broad_id_o     = fifo_head_i[sel_idx].id;
  assign broad_cpu_id_o = sel_idx;

  // ==============================
  // Priority update
  // ==============================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      // CPU 0 first
      prio_q <= NUM_CPU'(1);
    end
    else if (broad_wr_o)
    begin
      // One step along, regardless of who won
      prio_q <= rotl(prio_q, 1);
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_breq_tasks.svh
// ==============================
// Helpers
// ==============================
function automatic logic is_broad(input logic [MBUS_CMD_W-1:0] cmd);
  return (cmd == MBUS_CMD_WR_BROAD) || (cmd == MBUS_CMD_RD_BROAD);
endfunction

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
  begin
    $display("Mismatch at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    error_count++;
  end
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(posedge clk);
endtask

// Waits for the broadcast count to reach a target
task automatic wait_broads(input int target, input int limit);
  int n;
  n = 0;
  while (bc_cnt < target && n < limit)
  begin
    @(posedge clk);
    n++;
  end
  if (bc_cnt < target)
  begin
    $display("Timeout after %0d cycles: %0d broadcasts seen, %0d expected", limit, bc_cnt, target);
    error_count++;
  end
endtask

// Command on one CPU for a number of sampling edges, then NOP
task automatic hold_cmd(input int c, input logic [MBUS_CMD_W-1:0] cmd,
                        input logic [ADDR_W-1:0] addr, input int cycles);
  @(posedge clk);
  mbus_cmd[c]  <= cmd;
  mbus_addr[c] <= addr;
  repeat (cycles) @(posedge clk);
  mbus_cmd[c]  <= MBUS_CMD_NOP;
endtask

task automatic open_test();
  test_err0 = error_count;
endtask

task automatic close_test(input string name);
  tests_run++;
  if (error_count == test_err0)
  begin
    $display("Test %s: pass", name);
  end
  else
  begin
    $display("Test %s: fail, %0d errors", name, error_count - test_err0);
    tests_failed++;
  end
endtask

// ==============================
// Reference model
// ==============================
task automatic clear_model();
  model_prio = 0;
  model_base = '0;
  ack_prev   = '0;
  full_prev  = '0;
  seen_prev  = '0;
  for (int c = 0; c < NUM_CPU; c++)
  begin
    model_cnt[c] = 0;
    cmd_prev[c]  = mbus_cmd[c];
    addr_prev[c] = mbus_addr[c];
  end
endtask

// One clock cycle of the model, checked against the DUT
task automatic predict_cycle();
  logic [NUM_CPU-1:0] exp_ack;
  logic [NUM_CPU-1:0] full_now;
  logic               exp_wr;
  int                 sel;
  breq_entry_t        e;
  if (rst)
  begin
    clear_model();
  end
  else
  begin
    sel = -1;
    // Ack from last edge's command, own ack and FIFO full flag
    for (int c = 0; c < NUM_CPU; c++)
    begin
      exp_ack[c]  = is_broad(cmd_prev[c]) && !ack_prev[c] && !full_prev[c];
      full_now[c] = (model_cnt[c] >= BREQ_FIFO_DEPTH);
      compare($sformatf("mbus_ack_o[%0d]", c), mbus_ack[c], exp_ack[c]);
      if (mbus_ack[c] === 1'b1 && seen_prev[c])
      begin
        $display("CPU %0d was acknowledged in two consecutive cycles at %0t ns", c, $time);
        error_count++;
      end
      seen_prev[c] = (mbus_ack[c] === 1'b1);
      if (mbus_ack[c] === 1'b1)
      begin
        ack_total++;
      end
    end
    // First stored request at or after the priority holder
    for (int k = 0; k < NUM_CPU; k++)
    begin
      if (sel < 0 && model_cnt[(model_prio + k) % NUM_CPU] != 0)
      begin
        sel = (model_prio + k) % NUM_CPU;
      end
    end
    exp_wr = (sel >= 0) && !broad_full;
    compare("broad_wr_o", broad_wr, exp_wr);
    if (broad_wr === 1'b1)
    begin
      bc_cnt++;
      last_addr = broad_addr;
      last_type = broad_type;
      last_cpu  = broad_cpu_id;
      last_id   = broad_id;
      bc_id_log.push_back(broad_id);
      bc_cpu_log.push_back(broad_cpu_id);
    end
    if (exp_wr)
    begin
      e = model_mem[sel][0];
      if (broad_wr === 1'b1)
      begin
        compare("broad_cpu_id_o", broad_cpu_id, sel);
        compare("broad_addr_o", broad_addr, e.addr);
        compare("broad_type_o", broad_type, e.req_type);
        compare("broad_id_o", broad_id, e.id);
      end
      for (int i = 0; i < BREQ_FIFO_DEPTH - 1; i++)
      begin
        model_mem[sel][i] = model_mem[sel][i + 1];
      end
      model_cnt[sel]--;
      // Priority steps by one, not to the winner
      model_prio = (model_prio + 1) % NUM_CPU;
    end
    // Acked requests become visible next cycle
    for (int c = 0; c < NUM_CPU; c++)
    begin
      if (exp_ack[c])
      begin
        e.addr     = addr_prev[c];
        e.req_type = (cmd_prev[c] == MBUS_CMD_WR_BROAD) ? BREQ_TYPE_WR : BREQ_TYPE_RD;
        e.id       = {model_base, CPU_ID_W'(3 - c)};
        model_mem[c][model_cnt[c]] = e;
        model_cnt[c]++;
        ack_log.push_back(e.id);
      end
    end
    if (|exp_ack)
    begin
      model_base = model_base + 1'b1;
    end
    ack_prev  = exp_ack;
    full_prev = full_now;
    for (int c = 0; c < NUM_CPU; c++)
    begin
      cmd_prev[c]  = mbus_cmd[c];
      addr_prev[c] = mbus_addr[c];
    end
  end
endtask

// ==============================
// Directed tests
// ==============================
task automatic reset_quiet();
  open_test();
  idle_cycles(8);
  compare("mbus_ack_o count", ack_total, 0);
  compare("broad_wr_o count", bc_cnt, 0);
  close_test("reset");
endtask

task automatic ignore_plain_cmds();
  int a0;
  int b0;
  int pick;
  open_test();
  a0 = ack_total;
  b0 = bc_cnt;
  repeat (24)
  begin
    @(posedge clk);
    for (int c = 0; c < NUM_CPU; c++)
    begin
      pick = $unsigned($random(seed)) % 3;
      mbus_cmd[c]  <= (pick == 0) ? MBUS_CMD_NOP : (pick == 1) ? MBUS_CMD_WR : MBUS_CMD_RD;
      mbus_addr[c] <= $random(seed);
    end
  end
  @(posedge clk);
  for (int c = 0; c < NUM_CPU; c++)
  begin
    mbus_cmd[c] <= MBUS_CMD_NOP;
  end
  idle_cycles(4);
  compare("mbus_ack_o count", ack_total - a0, 0);
  compare("broad_wr_o count", bc_cnt - b0, 0);
  close_test("non-broadcast commands");
endtask

task automatic single_request();
  int                        a0;
  int                        b0;
  logic [ADDR_W-1:0]         addr;
  logic [BREQ_ID_BASE_W-1:0] base;
  open_test();
  // Write broadcast from CPU 2
  a0   = ack_total;
  b0   = bc_cnt;
  base = model_base;
  addr = $random(seed);
  hold_cmd(2, MBUS_CMD_WR_BROAD, addr, 1);
  wait_broads(b0 + 1, 20);
  idle_cycles(4);
  compare("mbus_ack_o count", ack_total - a0, 1);
  compare("broad_wr_o count", bc_cnt - b0, 1);
  compare("broad_addr_o", last_addr, addr);
  compare("broad_type_o", last_type, BREQ_TYPE_WR);
  compare("broad_cpu_id_o", last_cpu, 2);
  compare("broad_id_o", last_id, {base, 2'b01});
  // Read broadcast from CPU 1
  b0   = bc_cnt;
  base = model_base;
  addr = $random(seed);
  hold_cmd(1, MBUS_CMD_RD_BROAD, addr, 1);
  wait_broads(b0 + 1, 20);
  idle_cycles(4);
  compare("broad_addr_o", last_addr, addr);
  compare("broad_type_o", last_type, BREQ_TYPE_RD);
  compare("broad_cpu_id_o", last_cpu, 1);
  compare("broad_id_o", last_id, {base, 2'b10});
  close_test("single request");
endtask

task automatic held_command();
  int a0;
  int b0;
  open_test();
  a0 = ack_total;
  b0 = bc_cnt;
  // Twenty sampling edges, ack every other one
  hold_cmd(0, MBUS_CMD_WR_BROAD, $random(seed), 20);
  wait_broads(b0 + 10, 40);
  idle_cycles(4);
  compare("mbus_ack_o count", ack_total - a0, 10);
  compare("broad_wr_o count", bc_cnt - b0, 10);
  close_test("held command");
endtask

task automatic back_pressure();
  int a0;
  int b0;
  open_test();
  a0 = ack_total;
  b0 = bc_cnt;
  ack_log.delete();
  bc_id_log.delete();
  @(posedge clk);
  broad_full <= 1'b1;
  hold_cmd(3, MBUS_CMD_RD_BROAD, $random(seed), 12);
  idle_cycles(4);
  compare("mbus_ack_o count", ack_total - a0, BREQ_FIFO_DEPTH);
  compare("broad_wr_o count", bc_cnt - b0, 0);
  @(posedge clk);
  broad_full <= 1'b0;
  wait_broads(b0 + BREQ_FIFO_DEPTH, 20);
  idle_cycles(4);
  compare("broad_wr_o count", bc_cnt - b0, BREQ_FIFO_DEPTH);
  compare("broadcast log size", bc_id_log.size(), ack_log.size());
  // Drained in the order of acknowledge
  for (int i = 0; i < bc_id_log.size() && i < ack_log.size(); i++)
  begin
    compare($sformatf("broad_id_o #%0d", i), bc_id_log[i], ack_log[i]);
  end
  close_test("back-pressure");
endtask

task automatic round_robin();
  int a0;
  int b0;
  int pr;
  int want;
  int left [NUM_CPU];
  open_test();
  a0 = ack_total;
  b0 = bc_cnt;
  @(posedge clk);
  broad_full <= 1'b1;
  for (int c = 0; c < NUM_CPU; c++)
  begin
    mbus_cmd[c]  <= (c % 2 == 0) ? MBUS_CMD_WR_BROAD : MBUS_CMD_RD_BROAD;
    mbus_addr[c] <= $random(seed);
  end
  repeat (8) @(posedge clk);
  for (int c = 0; c < NUM_CPU; c++)
  begin
    mbus_cmd[c] <= MBUS_CMD_NOP;
  end
  idle_cycles(4);
  compare("mbus_ack_o count", ack_total - a0, NUM_CPU * BREQ_FIFO_DEPTH);
  compare("broad_wr_o count", bc_cnt - b0, 0);
  // Every FIFO full, priority where the last test left it
  pr = model_prio;
  for (int c = 0; c < NUM_CPU; c++)
  begin
    left[c] = BREQ_FIFO_DEPTH;
  end
  bc_cpu_log.delete();
  @(posedge clk);
  broad_full <= 1'b0;
  wait_broads(b0 + NUM_CPU * BREQ_FIFO_DEPTH, 40);
  idle_cycles(4);
  compare("broad_wr_o count", bc_cnt - b0, NUM_CPU * BREQ_FIFO_DEPTH);
  for (int k = 0; k < NUM_CPU * BREQ_FIFO_DEPTH; k++)
  begin
    want = -1;
    for (int j = 0; j < NUM_CPU; j++)
    begin
      if (want < 0 && left[(pr + j) % NUM_CPU] > 0)
      begin
        want = (pr + j) % NUM_CPU;
      end
    end
    left[want]--;
    pr = (pr + 1) % NUM_CPU;
    if (k < bc_cpu_log.size())
    begin
      compare($sformatf("broad_cpu_id_o #%0d", k), bc_cpu_log[k], want);
    end
  end
  close_test("round robin");
endtask

// File: tb/tb_breq_fifos.sv
`timescale 1ns/1ps
`default_nettype none

module tb_breq_fifos
  import breq_pkg::*;
();

  // ==============================
  // DUT signals
  // ==============================
  logic                   clk = 1'b0;
  logic                   rst;
  logic [MBUS_CMD_W-1:0]  mbus_cmd  [NUM_CPU];
  logic [ADDR_W-1:0]      mbus_addr [NUM_CPU];
  logic                   mbus_ack  [NUM_CPU];
  logic                   broad_full;
  logic                   broad_wr;
  logic [ADDR_W-1:0]      broad_addr;
  logic [BREQ_TYPE_W-1:0] broad_type;
  logic [CPU_ID_W-1:0]    broad_cpu_id;
  logic [BREQ_ID_W-1:0]   broad_id;

  // ==============================
  // Reference model state
  // ==============================
  breq_entry_t               model_mem [NUM_CPU][BREQ_FIFO_DEPTH];
  int                        model_cnt [NUM_CPU];
  // Index of the CPU holding priority
  int                        model_prio;
  logic [BREQ_ID_BASE_W-1:0] model_base;
  // Bus as it stood at the last edge
  logic [MBUS_CMD_W-1:0]     cmd_prev  [NUM_CPU];
  logic [ADDR_W-1:0]         addr_prev [NUM_CPU];
  logic [NUM_CPU-1:0]        ack_prev;
  logic [NUM_CPU-1:0]        full_prev;
  // Ack seen on the DUT in the last cycle
  logic [NUM_CPU-1:0]        seen_prev;

  // Observed traffic
  int                     ack_total = 0;
  int                     bc_cnt = 0;
  logic [ADDR_W-1:0]      last_addr;
  logic [BREQ_TYPE_W-1:0] last_type;
  logic [CPU_ID_W-1:0]    last_cpu;
  logic [BREQ_ID_W-1:0]   last_id;
  logic [BREQ_ID_W-1:0]   ack_log [$];
  logic [BREQ_ID_W-1:0]   bc_id_log [$];
  int                     bc_cpu_log [$];

  integer seed;
  int     error_count = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     test_err0;

  breq_fifos UUT (
    .clk            (clk),
    .rst            (rst),
    .mbus_cmd_i     (mbus_cmd),
    .mbus_addr_i    (mbus_addr),
    .mbus_ack_o     (mbus_ack),
    .broad_full_i   (broad_full),
    .broad_wr_o     (broad_wr),
    .broad_addr_o   (broad_addr),
    .broad_type_o   (broad_type),
    .broad_cpu_id_o (broad_cpu_id),
    .broad_id_o     (broad_id)
  );

  `include "tb_breq_tasks.svh"

  always #50 clk = ~clk;

  // Outputs settle well before the falling edge
  always @(negedge clk) predict_cycle();

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    seed = 32'h8b91e524;
    rst        <= 1'b1;
    broad_full <= 1'b0;
    for (int c = 0; c < NUM_CPU; c++)
    begin
      mbus_cmd[c]  <= MBUS_CMD_NOP;
      mbus_addr[c] <= '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    reset_quiet();
    ignore_plain_cmds();
    single_request();
    held_command();
    back_pressure();
    round_robin();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
    if (error_count == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
